// File: csr_defs.svh
// CSR unit constants
// Widths, addresses and encodings

`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

// One RV32 word
`define CSR_XLEN        32
`define CSR_INST_W      32
`define CSR_ADDR_W      12
`define CSR_REG_W       5
`define CSR_FUNCT3_W    3

// Bit positions in the instruction word
`define CSR_RD_LSB      7
`define CSR_FUNCT3_LSB  12
`define CSR_RS1_LSB     15
`define CSR_CSR_LSB     20

// Zicsr funct3 codes, bit 2 marks the immediate forms
`define CSR_F3_RW       3'b001
`define CSR_F3_RS       3'b010
`define CSR_F3_RC       3'b011
`define CSR_F3_RWI      3'b101
`define CSR_F3_RSI      3'b110
`define CSR_F3_RCI      3'b111

////////////////////////////////////////
// Machine CSR map
////////////////////////////////////////

`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344
`define CSR_MHARTID     12'hF14

// SD, 22:11, SPP/MPIE, 5:3, SIE/UIE
`define CSR_MSTATUS_WMASK   32'h807F_F9BB
// MXL=1, I extension only
`define CSR_MISA_VAL        32'h4000_0100
// Machine external interrupt, both in mie and mip
`define CSR_MEIP_BIT        11
// Global enable in mstatus
`define CSR_MIE_BIT         3

`endif

// File: csr_pkg.sv
// CSR unit types

`include "csr_defs.svh"

package csr_pkg;

    ////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////

    // Data word
    typedef logic [`CSR_XLEN-1:0]   xlen_t;
    // 12-bit CSR address
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    // Integer register index
    typedef logic [`CSR_REG_W-1:0]  reg_idx_t;

    // Operation, values follow funct3
    typedef enum logic [`CSR_FUNCT3_W-1:0] {
        CSR_OP_ILL = 3'b000,
        CSR_OP_RW  = `CSR_F3_RW,
        CSR_OP_RS  = `CSR_F3_RS,
        CSR_OP_RC  = `CSR_F3_RC,
        CSR_OP_RWI = `CSR_F3_RWI,
        CSR_OP_RSI = `CSR_F3_RSI,
        CSR_OP_RCI = `CSR_F3_RCI
    } csr_op_e;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Decoded instruction
    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     operand;
        reg_idx_t  rd;
        logic      write_req;
    } csr_req_t;

    // One-cycle CSR write strobe
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    // Status exported to the core
    typedef struct packed {
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mstatus;
        logic  meip;
    } csr_sb_t;

endpackage

// File: csr_decode.sv
// CSR instruction decode

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_decode import csr_pkg::*; (
    input  logic [`CSR_INST_W-1:0] instbus,
    input  xlen_t                  rs1_val,
    output reg_idx_t               rs1_addr,
    output csr_req_t               req
);

    logic [`CSR_FUNCT3_W-1:0] funct3;
    reg_idx_t                 rs1;
    reg_idx_t                 rd;
    csr_addr_t                csr;
    xlen_t                    zimm_ext;

    ////////////////////////////////////////
    // Field split
    ////////////////////////////////////////

    assign funct3 = instbus[`CSR_FUNCT3_LSB +: `CSR_FUNCT3_W];
    assign rs1    = instbus[`CSR_RS1_LSB +: `CSR_REG_W];
    assign rd     = instbus[`CSR_RD_LSB +: `CSR_REG_W];
    assign csr    = instbus[`CSR_CSR_LSB +: `CSR_ADDR_W];

    // rs1 field doubles as zimm
    assign zimm_ext = {{(`CSR_XLEN-`CSR_REG_W){1'b0}}, rs1};
    // Register file lookup, same cycle
    assign rs1_addr = rs1;

    ////////////////////////////////////////
    // Request build
    ////////////////////////////////////////

    always_comb begin
        req.addr      = csr;
        req.rd        = rd;
        // Immediate forms take zimm
        req.operand   = funct3[2] ? zimm_ext : rs1_val;
        req.op        = CSR_OP_ILL;
        req.write_req = 1'b0;
        case (funct3)
            `CSR_F3_RW:  req.op = CSR_OP_RW;
            `CSR_F3_RS:  req.op = CSR_OP_RS;
            `CSR_F3_RC:  req.op = CSR_OP_RC;
            `CSR_F3_RWI: req.op = CSR_OP_RWI;
            `CSR_F3_RSI: req.op = CSR_OP_RSI;
            `CSR_F3_RCI: req.op = CSR_OP_RCI;
            default:     req.op = CSR_OP_ILL;
        endcase
        // Swaps always write, set/clear only with a nonzero source
        case (req.op)
            CSR_OP_RW, CSR_OP_RWI: req.write_req = 1'b1;
            CSR_OP_ILL:            req.write_req = 1'b0;
            default:               req.write_req = (rs1 != '0);
        endcase
    end

endmodule

// File: csr_exec.sv
// CSR execution FSM

`timescale 1ns/1ps

module csr_exec import csr_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    // Instruction handshake
    input  logic      valid,
    output logic      ready,
    input  csr_req_t  req,
    // Register file read and write
    output csr_addr_t rd_addr,
    input  xlen_t     rd_data,
    output csr_wr_t   wr,
    // Integer register write-back
    output logic      rd_wr_en,
    output reg_idx_t  rd_wr_addr,
    output xlen_t     rd_wr_val
);

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE
    } state_e;

    state_e    state;
    logic      accept;
    csr_req_t  req_r;
    xlen_t     old_r;
    xlen_t     new_val;
    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;

    assign accept = valid & ready;

    // Old value looked up straight from the decoded address
    assign rd_addr = req.addr;

    ////////////////////////////////////////
    // Capture and new value
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (accept) begin
            req_r <= req;
            old_r <= rd_data;
        end
    end

    always_comb begin
        case (req_r.op)
            CSR_OP_RW, CSR_OP_RWI: new_val = req_r.operand;
            CSR_OP_RS, CSR_OP_RSI: new_val = old_r | req_r.operand;
            // RISC-V clear rule
            CSR_OP_RC, CSR_OP_RCI: new_val = old_r & ~req_r.operand;
            default:               new_val = old_r;
        endcase
    end

    // Payload launched together with the strobes
    always_ff @(posedge aclk) begin
        if (state == COMPUTE) begin
            wr_addr    <= req_r.addr;
            wr_data    <= new_val;
            rd_wr_addr <= req_r.rd;
            rd_wr_val  <= old_r;
        end
    end

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            ready    <= 1'b0;
            rd_wr_en <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    ready <= 1'b1;
                    if (accept) begin
                        ready <= 1'b0;
                        state <= COMPUTE;
                    end
                end
                // Strobes fire here for one cycle
                COMPUTE: begin
                    rd_wr_en <= 1'b1;
                    // Illegal funct3 only writes back
                    wr_en    <= req_r.write_req & (req_r.op != CSR_OP_ILL);
                    state    <= STORE;
                end
                // Let the CSR update settle before the next request
                STORE: begin
                    rd_wr_en <= 1'b0;
                    wr_en    <= 1'b0;
                    if (!rd_wr_en) begin
                        ready <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

// File: csr_regfile.sv
// Machine CSR storage
// Read mux, write masking, interrupt pending

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_regfile import csr_pkg::*; #(
    parameter int unsigned hart_id = 0
) (
    input  logic      aclk,
    input  logic      aresetn,
    // Asynchronous external interrupt
    input  logic      eirq,
    // Combinational read port
    input  csr_addr_t rd_addr,
    output xlen_t     rd_data,
    // Write strobe from the FSM
    input  csr_wr_t   wr,
    output csr_sb_t   csr_sb
);

    // Writable machine CSRs
    xlen_t      mstatus;
    xlen_t      mie;
    xlen_t      mtvec;
    xlen_t      mscratch;
    xlen_t      mepc;
    xlen_t      mcause;
    xlen_t      mtval;
    xlen_t      mip;

    logic [1:0] eirq_sync;
    logic       meip_set;
    logic       mip_wr;

    ////////////////////////////////////////
    // Interrupt synchronizer
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            eirq_sync <= 2'b00;
        end else begin
            eirq_sync <= {eirq_sync[0], eirq};
        end
    end

    // Pin, global enable and MEIE all needed
    assign meip_set = eirq_sync[1] & mstatus[`CSR_MIE_BIT] & mie[`CSR_MEIP_BIT];

    ////////////////////////////////////////
    // Software writes
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (wr.en) begin
            case (wr.addr)
                // Legal bits only
                `CSR_MSTATUS:  mstatus  <= wr.data & `CSR_MSTATUS_WMASK;
                `CSR_MIE:      mie      <= wr.data;
                `CSR_MTVEC:    mtvec    <= wr.data;
                `CSR_MSCRATCH: mscratch <= wr.data;
                // IALIGN=32
                `CSR_MEPC:     mepc     <= {wr.data[`CSR_XLEN-1:2], 2'b00};
                `CSR_MCAUSE:   mcause   <= wr.data;
                `CSR_MTVAL:    mtval    <= wr.data;
                // misa, mhartid, mip and unknown addresses
                default: ;
            endcase
        end
    end

    assign mip_wr = wr.en & (wr.addr == `CSR_MIP);

    // Pending external interrupt wins over a software write
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mip <= '0;
        end else if (meip_set) begin
            mip[`CSR_MEIP_BIT] <= 1'b1;
        end else if (mip_wr) begin
            mip <= wr.data;
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        case (rd_addr)
            `CSR_MSTATUS:  rd_data = mstatus;
            `CSR_MISA:     rd_data = `CSR_MISA_VAL;
            `CSR_MIE:      rd_data = mie;
            `CSR_MTVEC:    rd_data = mtvec;
            `CSR_MSCRATCH: rd_data = mscratch;
            `CSR_MEPC:     rd_data = mepc;
            `CSR_MCAUSE:   rd_data = mcause;
            `CSR_MTVAL:    rd_data = mtval;
            `CSR_MIP:      rd_data = mip;
            `CSR_MHARTID:  rd_data = xlen_t'(hart_id);
            // Unmapped reads as zero
            default:       rd_data = '0;
        endcase
    end

    ////////////////////////////////////////
    // Shared status bus
    ////////////////////////////////////////

    assign csr_sb = '{
        mtvec:   mtvec,
        mepc:    mepc,
        mstatus: mstatus,
        meip:    mip[`CSR_MEIP_BIT]
    };

endmodule

// File: csr_unit.sv
// CSR unit top level

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_unit import csr_pkg::*; #(
    parameter int unsigned hart_id = 0
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    // External interrupt pin
    input  logic                   eirq,
    // Instruction handshake
    input  logic                   valid,
    output logic                   ready,
    input  logic [`CSR_INST_W-1:0] instbus,
    // rs1 lookup in the integer register file
    output reg_idx_t               rs1_addr,
    input  xlen_t                  rs1_val,
    // Write-back, no back-pressure
    output logic                   rd_wr_en,
    output reg_idx_t               rd_wr_addr,
    output xlen_t                  rd_wr_val,
    // Status to the rest of the core
    output csr_sb_t                csr_sb
);

    csr_req_t  req;
    csr_addr_t rd_addr;
    xlen_t     rd_data;
    csr_wr_t   wr;

    // Zero-latency field split
    csr_decode csr_decode_i (
        .instbus  (instbus),
        .rs1_val  (rs1_val),
        .rs1_addr (rs1_addr),
        .req      (req)
    );

    // Three-state execution
    csr_exec csr_exec_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .ready      (ready),
        .req        (req),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .wr         (wr),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val)
    );

    // CSR storage
    csr_regfile #(
        .hart_id (hart_id)
    ) csr_regfile_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .eirq    (eirq),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr      (wr),
        .csr_sb  (csr_sb)
    );

endmodule

// File: csr_unit_chk.sv
// CSR unit handshake assertions

`timescale 1ns/1ps

module csr_unit_chk (
    input logic aclk,
    input logic aresetn,
    input logic valid,
    input logic ready,
    input logic rd_wr_en
);

    // Failure count
    int unsigned err_count = 0;
    logic        accept;

    assign accept = valid & ready;

    ////////////////////////////////////////
    // Write-back and handshake
    ////////////////////////////////////////

    // Strobe is one cycle wide
    wb_one_cycle: assert property (
        @(posedge aclk) disable iff (!aresetn) rd_wr_en |=> !rd_wr_en
    ) else begin
        err_count++;
        $error("rd_wr_en held high for two cycles");
    end

    // Busy right after acceptance
    ready_drop: assert property (
        @(posedge aclk) disable iff (!aresetn) accept |=> !ready
    ) else begin
        err_count++;
        $error("ready still high after acceptance");
    end

    // Strobe set on the edge after acceptance, seen one sample later
    wb_after_accept: assert property (
        @(posedge aclk) disable iff (!aresetn) accept |=> !rd_wr_en ##1 rd_wr_en
    ) else begin
        err_count++;
        $error("rd_wr_en not one cycle after acceptance");
    end

endmodule

bind csr_unit csr_unit_chk csr_unit_chk_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .valid    (valid),
    .ready    (ready),
    .rd_wr_en (rd_wr_en)
);

// File: csr_unit_tb.sv
// CSR unit testbench

`timescale 1ns/1ps

`include "csr_defs.svh"

module csr_unit_tb import csr_pkg::*; ();

    localparam int HART_ID = 5;
    localparam int TIMEOUT = 50;
    localparam int NROWS   = 26;
    localparam int NRAND   = 40;

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        reg_idx_t  src;
        xlen_t     val;
        xlen_t     exp;
    } row_t;

    logic                   aclk = 1'b0;
    logic                   aresetn;
    logic                   eirq;
    logic                   valid;
    logic                   ready;
    logic [`CSR_INST_W-1:0] instbus;
    reg_idx_t               rs1_addr;
    xlen_t                  rs1_val;
    logic                   rd_wr_en;
    reg_idx_t               rd_wr_addr;
    xlen_t                  rd_wr_val;
    csr_sb_t                csr_sb;

    // Shadow CSR state
    xlen_t m_mstatus = '0;
    xlen_t m_mie = '0;
    xlen_t m_mtvec = '0;
    xlen_t m_mscratch = '0;
    xlen_t m_mepc = '0;
    xlen_t m_mcause = '0;
    xlen_t m_mtval = '0;
    xlen_t m_mip = '0;

    logic [31:0] lfsr_state = 32'hd85fcdda;

    // op, address, rs1 index or zimm, rs1 value, old value expected back
    row_t rows [NROWS] = '{
        '{CSR_OP_RS,  `CSR_MSCRATCH, 5'd0,  32'h0000_0000, 32'h0000_0000},
        '{CSR_OP_RS,  `CSR_MISA,     5'd0,  32'h0000_0000, `CSR_MISA_VAL},
        '{CSR_OP_RS,  `CSR_MHARTID,  5'd0,  32'h0000_0000, 32'h0000_0005},
        '{CSR_OP_RW,  `CSR_MSCRATCH, 5'd1,  32'hA5A5_5A5A, 32'h0000_0000},
        '{CSR_OP_RWI, `CSR_MSCRATCH, 5'h15, 32'hFFFF_FFFF, 32'hA5A5_5A5A},
        '{CSR_OP_RS,  `CSR_MSCRATCH, 5'd0,  32'h0000_0000, 32'h0000_0015},
        '{CSR_OP_RW,  `CSR_MTVEC,    5'd2,  32'h0000_1000, 32'h0000_0000},
        '{CSR_OP_RS,  `CSR_MTVEC,    5'd3,  32'h0000_00F1, 32'h0000_1000},
        '{CSR_OP_RC,  `CSR_MTVEC,    5'd4,  32'h0000_0031, 32'h0000_10F1},
        '{CSR_OP_RSI, `CSR_MTVEC,    5'h0E, 32'h0000_0000, 32'h0000_10C0},
        '{CSR_OP_RCI, `CSR_MTVEC,    5'h06, 32'h0000_0000, 32'h0000_10CE},
        '{CSR_OP_RSI, `CSR_MTVEC,    5'd0,  32'h0000_0000, 32'h0000_10C8},
        '{CSR_OP_RCI, `CSR_MTVEC,    5'd0,  32'h0000_0000, 32'h0000_10C8},
        '{CSR_OP_RC,  `CSR_MTVEC,    5'd0,  32'hFFFF_FFFF, 32'h0000_10C8},
        '{CSR_OP_RW,  `CSR_MSTATUS,  5'd5,  32'hFFFF_FFFF, 32'h0000_0000},
        '{CSR_OP_RW,  `CSR_MEPC,     5'd6,  32'h8000_0007, 32'h0000_0000},
        '{CSR_OP_RS,  `CSR_MEPC,     5'd0,  32'h0000_0000, 32'h8000_0004},
        '{CSR_OP_RW,  `CSR_MISA,     5'd7,  32'h0000_0000, `CSR_MISA_VAL},
        '{CSR_OP_RW,  `CSR_MHARTID,  5'd8,  32'h0000_FFFF, 32'h0000_0005},
        '{CSR_OP_RW,  12'h7C0,       5'd9,  32'h0000_1234, 32'h0000_0000},
        '{CSR_OP_RS,  12'h7C0,       5'd0,  32'h0000_0000, 32'h0000_0000},
        '{CSR_OP_ILL, `CSR_MSCRATCH, 5'd1,  32'hFFFF_FFFF, 32'h0000_0015},
        '{CSR_OP_RC,  `CSR_MSTATUS,  5'd10, 32'hFFFF_FFFF, `CSR_MSTATUS_WMASK},
        '{CSR_OP_RS,  `CSR_MSCRATCH, 5'd0,  32'h0000_0000, 32'h0000_0015},
        '{CSR_OP_RS,  `CSR_MISA,     5'd0,  32'h0000_0000, `CSR_MISA_VAL},
        '{CSR_OP_RS,  `CSR_MHARTID,  5'd0,  32'h0000_0000, 32'h0000_0005}
    };

    csr_op_e   op_list [6] = '{CSR_OP_RW, CSR_OP_RS, CSR_OP_RC,
                               CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI};
    csr_addr_t rand_addrs [4] = '{`CSR_MSCRATCH, `CSR_MTVEC, `CSR_MIE, `CSR_MEPC};

    always #10 aclk = ~aclk;

    csr_unit #(
        .hart_id (HART_ID)
    ) csr_unit_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .eirq       (eirq),
        .valid      (valid),
        .ready      (ready),
        .instbus    (instbus),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .csr_sb     (csr_sb)
    );

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One step per bit
    function automatic xlen_t take_bits(int n);
        xlen_t v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[`CSR_XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic xlen_t model_read(csr_addr_t a);
        case (a)
            `CSR_MSTATUS:  return m_mstatus;
            `CSR_MISA:     return `CSR_MISA_VAL;
            `CSR_MIE:      return m_mie;
            `CSR_MTVEC:    return m_mtvec;
            `CSR_MSCRATCH: return m_mscratch;
            `CSR_MEPC:     return m_mepc;
            `CSR_MCAUSE:   return m_mcause;
            `CSR_MTVAL:    return m_mtval;
            `CSR_MIP:      return m_mip;
            `CSR_MHARTID:  return xlen_t'(HART_ID);
            default:       return '0;
        endcase
    endfunction

    // Read-only and unmapped addresses ignore writes
    task automatic model_write(csr_addr_t a, xlen_t d);
        case (a)
            `CSR_MSTATUS:  m_mstatus = d & `CSR_MSTATUS_WMASK;
            `CSR_MIE:      m_mie = d;
            `CSR_MTVEC:    m_mtvec = d;
            `CSR_MSCRATCH: m_mscratch = d;
            `CSR_MEPC:     m_mepc = d & ~xlen_t'(3);
            `CSR_MCAUSE:   m_mcause = d;
            `CSR_MTVAL:    m_mtval = d;
            `CSR_MIP:      m_mip = d;
            default: ;
        endcase
    endtask

    function automatic xlen_t new_value(csr_op_e op, xlen_t old, xlen_t operand);
        case (op)
            CSR_OP_RW, CSR_OP_RWI: return operand;
            CSR_OP_RS, CSR_OP_RSI: return old | operand;
            CSR_OP_RC, CSR_OP_RCI: return old & ~operand;
            default:               return old;
        endcase
    endfunction

    ////////////////////////////////////////
    // Checks and bus tasks
    ////////////////////////////////////////

    task automatic fail_stop(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_eq(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
            if (n > TIMEOUT) fail_stop("timeout while waiting for ready to rise");
        end while (!ready);
    endtask

    // Issue one instruction and check write-back, timing and status bus
    task automatic exec_check(input csr_op_e op, input csr_addr_t addr, input reg_idx_t src,
                              input xlen_t val, input reg_idx_t rd, output xlen_t wb);
        xlen_t old;
        xlen_t operand;
        int    n;
        int    m;
        old = model_read(addr);
        operand = (op inside {CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI}) ? xlen_t'(src) : val;
        wait_ready();
        @(posedge aclk);
        valid   <= 1'b1;
        instbus <= {addr, src, op, rd, 7'b1110011};
        rs1_val <= val;
        @(negedge aclk);
        check_eq("rs1_addr", xlen_t'(rs1_addr), xlen_t'(src));
        // Accepted on this edge
        @(posedge aclk);
        valid <= 1'b0;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
            if (n > TIMEOUT) fail_stop("timeout while waiting for the write-back strobe");
        end while (!rd_wr_en);
        check_eq("rd_wr_en delay", xlen_t'(n), 32'd2);
        check_eq("rd_wr_addr", xlen_t'(rd_wr_addr), xlen_t'(rd));
        wb = rd_wr_val;
        check_eq("rd_wr_val", wb, old);
        m = 0;
        do begin
            @(negedge aclk);
            m++;
            if (m > TIMEOUT) fail_stop("timeout while waiting for ready after write-back");
        end while (!ready);
        check_eq("ready low cycles", xlen_t'(n + m - 1), 32'd3);
        // Swaps always write, set and clear only with a nonzero source
        if (op inside {CSR_OP_RW, CSR_OP_RWI} ||
            (op inside {CSR_OP_RS, CSR_OP_RSI, CSR_OP_RC, CSR_OP_RCI} && src != '0)) begin
            model_write(addr, new_value(op, old, operand));
        end
        if (eirq && m_mstatus[`CSR_MIE_BIT] && m_mie[`CSR_MEIP_BIT]) begin
            m_mip[`CSR_MEIP_BIT] = 1'b1;
        end
        check_eq("csr_sb.mtvec", csr_sb.mtvec, m_mtvec);
        check_eq("csr_sb.mepc", csr_sb.mepc, m_mepc);
        check_eq("csr_sb.mstatus", csr_sb.mstatus, m_mstatus);
        check_eq("csr_sb.meip", xlen_t'(csr_sb.meip), xlen_t'(m_mip[`CSR_MEIP_BIT]));
    endtask

    // Observation window with the interrupt blocked
    task automatic hold_meip_low(int cycles);
        repeat (cycles) begin
            @(negedge aclk);
            check_eq("csr_sb.meip", xlen_t'(csr_sb.meip), 32'd0);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        xlen_t     wb;
        csr_op_e   op;
        csr_addr_t addr;
        reg_idx_t  src;
        reg_idx_t  rd;
        xlen_t     val;
        int        n;
        aresetn = 1'b0;
        eirq    = 1'b0;
        valid   = 1'b0;
        instbus = '0;
        rs1_val = '0;
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;
        wait_ready();
        check_eq("rd_wr_en", xlen_t'(rd_wr_en), 32'd0);

        // Directed table
        for (int i = 0; i < NROWS; i++) begin
            exec_check(rows[i].op, rows[i].addr, rows[i].src, rows[i].val,
                       reg_idx_t'(i % 31 + 1), wb);
            check_eq("table rd_wr_val", wb, rows[i].exp);
        end

        // Random rounds on the plain registers
        for (int r = 0; r < NRAND; r++) begin
            addr = rand_addrs[take_bits(2)];
            op   = op_list[take_bits(3) % 6];
            src  = reg_idx_t'(take_bits(5));
            val  = take_bits(32);
            rd   = reg_idx_t'(take_bits(5));
            exec_check(op, addr, src, val, rd, wb);
        end

        // External interrupt, one enable missing at a time
        @(posedge aclk);
        eirq <= 1'b1;
        exec_check(CSR_OP_RW, `CSR_MIE, 5'd1, 32'h0, 5'd1, wb);
        exec_check(CSR_OP_RW, `CSR_MSTATUS, 5'd2, 32'h8, 5'd2, wb);
        hold_meip_low(8);
        exec_check(CSR_OP_RS, `CSR_MIP, 5'd0, 32'h0, 5'd3, wb);
        exec_check(CSR_OP_RW, `CSR_MSTATUS, 5'd2, 32'h0, 5'd2, wb);
        exec_check(CSR_OP_RW, `CSR_MIE, 5'd1, 32'h800, 5'd1, wb);
        hold_meip_low(8);
        exec_check(CSR_OP_RW, `CSR_MSTATUS, 5'd2, 32'h8, 5'd2, wb);
        n = 0;
        do begin
            @(negedge aclk);
            n++;
            if (n > TIMEOUT) fail_stop("timeout while waiting for csr_sb.meip");
        end while (!csr_sb.meip);
        exec_check(CSR_OP_RS, `CSR_MIP, 5'd0, 32'h0, 5'd3, wb);

        if (csr_unit_i.csr_unit_chk_i.err_count != 0) begin
            fail_stop("a handshake assertion failed during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_exec.sv
csr_regfile.sv
csr_unit.sv
csr_unit_chk.sv
csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - csr_pkg.sv
  - csr_decode.sv
  - csr_exec.sv
  - csr_regfile.sv
  - csr_unit.sv
  - target: test
    files:
      - csr_unit_chk.sv
      - csr_unit_tb.sv
